/* hdl/pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Fixed words and addresses
//////////////////////////////////////////////////////////////////////
`define ERET_WORD    32'h4200_0018
`define HANDLER_ADDR 32'h0000_4180
`define RESET_ADDR   32'h0000_3000

//////////////////////////////////////////////////////////////////////
// Opcode and funct fields
//////////////////////////////////////////////////////////////////////
`define OP_SPECIAL   6'b000000
`define OP_SPECIAL2  6'b011100
`define OP_ORI       6'b001101
`define OP_LUI       6'b001111
`define FUNCT_ADDU   6'b100001
`define FUNCT_SUBU   6'b100011
`define FUNCT_AND    6'b100100
`define FUNCT_OR     6'b100101
`define FUNCT_MUL    6'b000010

`endif

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    // R-type view of an instruction word
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_view_t;

    // I-type view of the same word
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_word_u;

    typedef enum logic [4:0] {
        ALU_NOP = 5'd0,
        ALU_ADD = 5'd1,
        ALU_SUB = 5'd2,
        ALU_AND = 5'd3,
        ALU_OR  = 5'd4,
        ALU_LUI = 5'd5,
        ALU_MUL = 5'd6
    } alu_op_e;

endpackage

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module instr_decoder (
    input  pipe_pkg::instr_word_u instr,
    output pipe_pkg::alu_op_e     alu_op,
    output logic                  wr_en,
    output logic [4:0]            wr_addr,
    output logic [4:0]            rs_addr,
    output logic [4:0]            rt_addr,
    output logic                  use_rt,
    output logic [31:0]           imm_ext,
    output logic [2:0]            tnew_d,
    output logic                  unknown
);

    logic writes;   // Instruction names a destination
    logic r_ok;     // Legal R-type form
    logic i_type;   // ori or lui
    logic is_eret;

    assign r_ok    = (instr.r.shamt == 5'd0);
    assign i_type  = (instr.i.op == `OP_ORI) || (instr.i.op == `OP_LUI);
    assign is_eret = (instr == `ERET_WORD);
    assign wr_en   = writes && (wr_addr != 5'd0);   // Writes to $0 are dropped

    //////////////////////////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        alu_op  = pipe_pkg::ALU_NOP;
        imm_ext = 32'd0;
        case (instr.r.op)
            `OP_SPECIAL: begin
                if (r_ok) begin
                    case (instr.r.funct)
                        `FUNCT_ADDU: alu_op = pipe_pkg::ALU_ADD;
                        `FUNCT_SUBU: alu_op = pipe_pkg::ALU_SUB;
                        `FUNCT_AND:  alu_op = pipe_pkg::ALU_AND;
                        `FUNCT_OR:   alu_op = pipe_pkg::ALU_OR;
                        default:     alu_op = pipe_pkg::ALU_NOP;
                    endcase
                end
            end
            `OP_SPECIAL2: begin
                if (r_ok && instr.r.funct == `FUNCT_MUL) alu_op = pipe_pkg::ALU_MUL;
            end
            `OP_ORI: begin
                alu_op  = pipe_pkg::ALU_OR;
                imm_ext = {16'd0, instr.i.imm};     // Zero extend
            end
            `OP_LUI: begin
                alu_op  = pipe_pkg::ALU_LUI;
                imm_ext = {instr.i.imm, 16'd0};     // Upper half
            end
            default: alu_op = pipe_pkg::ALU_NOP;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register fields and tnew
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        writes  = 1'b0;
        wr_addr = 5'd0;
        rs_addr = 5'd0;
        rt_addr = 5'd0;
        use_rt  = 1'b0;
        tnew_d  = 3'd0;
        unknown = 1'b0;
        if (alu_op == pipe_pkg::ALU_NOP) begin
            unknown = !is_eret;     // eret is legal and redirects in E
        end else if (i_type) begin
            writes  = 1'b1;
            wr_addr = instr.i.rt;
            rs_addr = (instr.i.op == `OP_LUI) ? 5'd0 : instr.i.rs;
            tnew_d  = 3'd1;
        end else begin
            writes  = 1'b1;
            wr_addr = instr.r.rd;
            rs_addr = instr.r.rs;
            rt_addr = instr.r.rt;
            use_rt  = 1'b1;
            tnew_d  = (alu_op == pipe_pkg::ALU_MUL) ? 3'd2 : 3'd1;  // Product done in M
        end
    end

endmodule

/* hdl/hazard_ctrl.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module hazard_ctrl (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        use_rt,
    input  logic [4:0]  rd_e,
    input  logic        wr_e,
    input  logic [2:0]  tnew_e,
    input  logic        exc_req,
    input  logic [31:0] instr_e,
    output logic        stall_d,
    output logic        clr_e,
    output logic        jump_handler
);

    logic rs_hit;
    logic rt_hit;
    logic e_busy;       // E writes a register whose value is not ready
    logic eret_e;

    assign e_busy = wr_e && (rd_e != 5'd0) && (tnew_e != 3'd0);
    assign rs_hit = (rs_addr != 5'd0) && (rs_addr == rd_e);
    assign rt_hit = use_rt && (rt_addr != 5'd0) && (rt_addr == rd_e);
    assign eret_e = (instr_e == `ERET_WORD);

    // A redirect discards D anyway, so there is nothing to hold
    assign stall_d      = e_busy && (rs_hit || rt_hit) && !exc_req && !eret_e;
    assign clr_e        = stall_d;  // Bubble into E while D holds
    assign jump_handler = exc_req;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Redirect and bubble are never requested while the pipe resets
    a_no_ctrl_in_reset : assert property (
        @(posedge clk) reset |-> (!jump_handler && !clr_e)
    ) else $error("hazard_ctrl: redirect or clear during reset");

    // The bubble inserted in E always resolves the hazard next cycle
    a_stall_one_cycle : assert property (
        @(posedge clk) disable iff (reset) stall_d |=> !stall_d
    ) else $error("hazard_ctrl: stall_d held for more than one cycle");

endmodule

/* hdl/flow_reg_e.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module flow_reg_e (
    input  logic               clk,
    input  logic               reset,
    input  logic               clr_e,
    input  logic               jump_handler,
    input  logic [31:0]        epc,
    input  pipe_pkg::alu_op_e  alu_op,
    input  logic               wr_en,
    input  logic [4:0]         wr_addr,
    input  logic [4:0]         rs_addr,
    input  logic [4:0]         rt_addr,
    input  logic [31:0]        rs_data,
    input  logic [31:0]        rt_data,
    input  logic [31:0]        imm_ext,
    input  logic               use_rt,
    input  logic [2:0]         tnew_d,
    input  logic               unknown,
    input  logic [31:0]        instr,
    input  logic [31:0]        instr_addr,
    output pipe_pkg::alu_op_e  alu_op_e,
    output logic               wr_e,
    output logic [4:0]         rd_e,
    output logic [4:0]         rs_addr_e,
    output logic [4:0]         rt_addr_e,
    output logic [31:0]        rs_data_e,
    output logic [31:0]        rt_data_e,
    output logic [31:0]        imm_ext_e,
    output logic               use_rt_e,
    output logic [2:0]         tnew_e,
    output logic               unknown_e,
    output logic [31:0]        instr_e,
    output logic [31:0]        e_addr
);

    logic eret_e;
    logic flush;    // Any case that loads a bubble

    assign eret_e = (instr_e == `ERET_WORD);
    assign flush  = reset || jump_handler || clr_e || eret_e;

    //////////////////////////////////////////////////////////////////////
    // Address in E
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset)              e_addr <= `RESET_ADDR;
        else if (jump_handler)  e_addr <= `HANDLER_ADDR;
        else if (clr_e)         e_addr <= instr_addr;   // Bubble keeps the address
        else if (eret_e)        e_addr <= epc;
        else                    e_addr <= instr_addr;
    end

    //////////////////////////////////////////////////////////////////////
    // Control and payload fields
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (flush) begin
            alu_op_e  <= pipe_pkg::ALU_NOP;
            wr_e      <= 1'b0;
            rd_e      <= 5'd0;
            rs_addr_e <= 5'd0;
            rt_addr_e <= 5'd0;
            rs_data_e <= 32'd0;
            rt_data_e <= 32'd0;
            imm_ext_e <= 32'd0;
            use_rt_e  <= 1'b0;
            tnew_e    <= 3'd0;
            unknown_e <= 1'b0;
            instr_e   <= 32'd0;
        end else begin
            alu_op_e  <= alu_op;
            wr_e      <= wr_en;
            rd_e      <= wr_addr;
            rs_addr_e <= rs_addr;
            rt_addr_e <= rt_addr;
            rs_data_e <= rs_data;
            rt_data_e <= rt_data;
            imm_ext_e <= imm_ext;
            use_rt_e  <= use_rt;
            tnew_e    <= (tnew_d != 3'd0) ? tnew_d - 3'd1 : 3'd0;   // One stage closer
            unknown_e <= unknown;
            instr_e   <= instr;
        end
    end

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::alu_op_e alu_op_e,
    input  logic              wr_e,
    input  logic [4:0]        rd_e,
    input  logic [4:0]        rs_addr_e,
    input  logic [4:0]        rt_addr_e,
    input  logic [31:0]       rs_data_e,
    input  logic [31:0]       rt_data_e,
    input  logic [31:0]       imm_ext_e,
    input  logic              use_rt_e,
    output logic              m_wr_en,
    output logic [4:0]        m_wr_addr,
    output logic [31:0]       m_result
);

    logic        fwd_rs;
    logic        fwd_rt;
    logic [31:0] op_a;
    logic [31:0] rt_val;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] alu_m;     // ALU result held in M
    logic [31:0] mul_a;
    logic [31:0] mul_b;
    logic        mul_m;     // M holds a mul

    // Forward from M when it writes the operand's register
    assign fwd_rs = m_wr_en && (rs_addr_e != 5'd0) && (m_wr_addr == rs_addr_e);
    assign fwd_rt = m_wr_en && (rt_addr_e != 5'd0) && (m_wr_addr == rt_addr_e);
    assign op_a   = fwd_rs ? m_result : rs_data_e;
    assign rt_val = fwd_rt ? m_result : rt_data_e;
    assign op_b   = use_rt_e ? rt_val : imm_ext_e;

    always_comb begin
        case (alu_op_e)
            pipe_pkg::ALU_ADD: alu_res = op_a + op_b;
            pipe_pkg::ALU_SUB: alu_res = op_a - op_b;
            pipe_pkg::ALU_AND: alu_res = op_a & op_b;
            pipe_pkg::ALU_OR:  alu_res = op_a | op_b;
            pipe_pkg::ALU_LUI: alu_res = op_b;
            default:           alu_res = 32'd0;     // mul finishes in M
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // M-stage result register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            m_wr_en <= 1'b0;
            mul_m   <= 1'b0;
        end else begin
            m_wr_en <= wr_e;
            mul_m   <= (alu_op_e == pipe_pkg::ALU_MUL);
        end
    end

    always_ff @(posedge clk) begin
        m_wr_addr <= rd_e;
        alu_m     <= alu_res;
        mul_a     <= op_a;  // Second cycle of the multiply
        mul_b     <= op_b;
    end

    assign m_result = mul_m ? mul_a * mul_b : alu_m;

    // The decoder never lets a $0 destination through
    a_no_reg0_write : assert property (
        @(posedge clk) disable iff (reset) m_wr_en |-> (m_wr_addr != 5'd0)
    ) else $error("exec_unit: write-back to register 0");

endmodule

/* hdl/exec_core_top.sv */
`timescale 1ns/1ps

module exec_core_top (
    input  logic                  clk,
    input  logic                  reset,
    input  pipe_pkg::instr_word_u instr,
    input  logic [31:0]           instr_addr,
    input  logic [31:0]           rs_data,
    input  logic [31:0]           rt_data,
    input  logic                  exc_req,
    input  logic [31:0]           epc,
    output logic                  stall_d,
    output logic [31:0]           e_addr,
    output logic                  unknown_e,
    output logic                  m_wr_en,
    output logic [4:0]            m_wr_addr,
    output logic [31:0]           m_result
);

    // D-stage fields
    pipe_pkg::alu_op_e alu_op_d;
    logic              wr_en_d;
    logic [4:0]        wr_addr_d;
    logic [4:0]        rs_addr_d;
    logic [4:0]        rt_addr_d;
    logic              use_rt_d;
    logic [31:0]       imm_ext_d;
    logic [2:0]        tnew_d;
    logic              unknown_d;

    // E-stage fields
    pipe_pkg::alu_op_e alu_op_e;
    logic              wr_e;
    logic [4:0]        rd_e;
    logic [4:0]        rs_addr_e;
    logic [4:0]        rt_addr_e;
    logic [31:0]       rs_data_e;
    logic [31:0]       rt_data_e;
    logic [31:0]       imm_ext_e;
    logic              use_rt_e;
    logic [2:0]        tnew_e;
    logic [31:0]       instr_e;

    logic              clr_e;
    logic              jump_handler;

    instr_decoder u_dec (
        .instr(instr), .alu_op(alu_op_d), .wr_en(wr_en_d), .wr_addr(wr_addr_d),
        .rs_addr(rs_addr_d), .rt_addr(rt_addr_d), .use_rt(use_rt_d),
        .imm_ext(imm_ext_d), .tnew_d(tnew_d), .unknown(unknown_d)
    );

    hazard_ctrl u_hzd (
        .clk(clk), .reset(reset), .rs_addr(rs_addr_d), .rt_addr(rt_addr_d),
        .use_rt(use_rt_d), .rd_e(rd_e), .wr_e(wr_e), .tnew_e(tnew_e),
        .exc_req(exc_req), .instr_e(instr_e), .stall_d(stall_d), .clr_e(clr_e),
        .jump_handler(jump_handler)
    );

    flow_reg_e u_fre (
        .clk(clk), .reset(reset), .clr_e(clr_e), .jump_handler(jump_handler), .epc(epc),
        .alu_op(alu_op_d), .wr_en(wr_en_d), .wr_addr(wr_addr_d), .rs_addr(rs_addr_d),
        .rt_addr(rt_addr_d), .rs_data(rs_data), .rt_data(rt_data), .imm_ext(imm_ext_d),
        .use_rt(use_rt_d), .tnew_d(tnew_d), .unknown(unknown_d), .instr(instr),
        .instr_addr(instr_addr), .alu_op_e(alu_op_e), .wr_e(wr_e), .rd_e(rd_e),
        .rs_addr_e(rs_addr_e), .rt_addr_e(rt_addr_e), .rs_data_e(rs_data_e),
        .rt_data_e(rt_data_e), .imm_ext_e(imm_ext_e), .use_rt_e(use_rt_e),
        .tnew_e(tnew_e), .unknown_e(unknown_e), .instr_e(instr_e), .e_addr(e_addr)
    );

    exec_unit u_exe (
        .clk(clk), .reset(reset), .alu_op_e(alu_op_e), .wr_e(wr_e), .rd_e(rd_e),
        .rs_addr_e(rs_addr_e), .rt_addr_e(rt_addr_e), .rs_data_e(rs_data_e),
        .rt_data_e(rt_data_e), .imm_ext_e(imm_ext_e), .use_rt_e(use_rt_e),
        .m_wr_en(m_wr_en), .m_wr_addr(m_wr_addr), .m_result(m_result)
    );

endmodule

/* verification/exec_core_tb.sv */
`timescale 1ns/1ps
`include "pipe_defines.svh"

module exec_core_tb;

    localparam logic [31:0] NOP_WORD   = 32'h3400_0000;  // ori $0, $0, 0
    localparam logic [31:0] NOP_ADDR   = 32'h0000_2ffc;
    localparam logic [31:0] EPC_VALUE  = 32'h0000_3100;
    localparam int          MAX_CYCLES = 200;

    logic                  clk;
    logic                  reset;
    pipe_pkg::instr_word_u instr;
    logic [31:0]           instr_addr;
    logic [31:0]           rs_data;
    logic [31:0]           rt_data;
    logic                  exc_req;
    logic [31:0]           epc;
    logic                  stall_d;
    logic [31:0]           e_addr;
    logic                  unknown_e;
    logic                  m_wr_en;
    logic [4:0]            m_wr_addr;
    logic [31:0]           m_result;

    logic [31:0] regs [32];     // Architectural registers in program order
    logic [4:0]  last_wr;       // Destination still in flight for the next read
    logic [31:0] last_old;
    logic [31:0] tab_word [$];
    logic        tab_exc [$];
    logic        tab_stall [$];
    int          exp_due [$];
    logic [4:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_e_addr;
    logic        exp_unknown;
    logic        eret_next;
    int          cyc;
    int          errors;
    int          checks;

    exec_core_top uut (
        .clk(clk), .reset(reset), .instr(instr), .instr_addr(instr_addr),
        .rs_data(rs_data), .rt_data(rt_data), .exc_req(exc_req), .epc(epc),
        .stall_d(stall_d), .e_addr(e_addr), .unknown_e(unknown_e),
        .m_wr_en(m_wr_en), .m_wr_addr(m_wr_addr), .m_result(m_result)
    );

    always #50 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [5:0] funct);
        return {op, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic exc, input logic stall);
        tab_word.push_back(word);
        tab_exc.push_back(exc);
        tab_stall.push_back(stall);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program of words with exception requests and expected stalls
    //////////////////////////////////////////////////////////////////////
    task automatic load_program();
        add_entry(enc_i(`OP_ORI, 5'd0, 5'd1, 16'h1234), 1'b0, 1'b0);
        add_entry(enc_r(`OP_SPECIAL, 5'd1, 5'd3, 5'd2, `FUNCT_ADDU), 1'b0, 1'b0); // Forward rs
        add_entry(enc_r(`OP_SPECIAL, 5'd2, 5'd1, 5'd4, `FUNCT_SUBU), 1'b0, 1'b0);
        add_entry(enc_r(`OP_SPECIAL, 5'd4, 5'd2, 5'd5, `FUNCT_AND), 1'b0, 1'b0);
        add_entry(enc_r(`OP_SPECIAL, 5'd5, 5'd5, 5'd6, `FUNCT_OR), 1'b0, 1'b0);  // Both operands
        add_entry(enc_i(`OP_LUI, 5'd0, 5'd7, 16'habcd), 1'b0, 1'b0);
        add_entry(enc_r(`OP_SPECIAL2, 5'd7, 5'd6, 5'd8, `FUNCT_MUL), 1'b0, 1'b0);
        add_entry(enc_r(`OP_SPECIAL, 5'd8, 5'd1, 5'd9, `FUNCT_ADDU), 1'b0, 1'b1); // Waits on mul
        add_entry(enc_r(`OP_SPECIAL2, 5'd9, 5'd9, 5'd10, `FUNCT_MUL), 1'b0, 1'b0);
        add_entry(enc_r(`OP_SPECIAL, 5'd0, 5'd10, 5'd11, `FUNCT_OR), 1'b0, 1'b1); // rt hazard
        add_entry(enc_r(`OP_SPECIAL, 5'd11, 5'd2, 5'd12, `FUNCT_ADDU), 1'b1, 1'b0);
        add_entry(`ERET_WORD, 1'b0, 1'b0);
        add_entry(enc_r(`OP_SPECIAL, 5'd12, 5'd12, 5'd13, `FUNCT_ADDU), 1'b0, 1'b0);
        add_entry(32'h8c01_0004, 1'b0, 1'b0);                                   // Unsupported lw
        add_entry(enc_r(`OP_SPECIAL, 5'd13, 5'd11, 5'd14, `FUNCT_SUBU), 1'b0, 1'b0);
        add_entry(enc_i(`OP_ORI, 5'd1, 5'd0, 16'hffff), 1'b0, 1'b0);            // Targets $0
        add_entry(enc_r(`OP_SPECIAL, 5'd14, 5'd13, 5'd15, `FUNCT_ADDU), 1'b0, 1'b0);
    endtask

    // Register file read that misses the previous instruction's result
    function automatic logic [31:0] reg_read(input logic [4:0] a);
        if (a == 5'd0) return 32'd0;
        if (last_wr != 5'd0 && a == last_wr) return last_old;
        return regs[a];
    endfunction

    task automatic ref_execute(input pipe_pkg::instr_word_u w, output logic legal,
                               output logic wr, output logic [4:0] dst, output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        logic        r_form;
        a      = regs[w.r.rs];
        b      = regs[w.r.rt];
        r_form = (w.r.shamt == 5'd0);
        legal  = 1'b1;
        dst    = w.r.rd;
        val    = 32'd0;
        if (w == `ERET_WORD) dst = 5'd0;
        else if (w.r.op == `OP_SPECIAL && r_form && w.r.funct == `FUNCT_ADDU) val = a + b;
        else if (w.r.op == `OP_SPECIAL && r_form && w.r.funct == `FUNCT_SUBU) val = a - b;
        else if (w.r.op == `OP_SPECIAL && r_form && w.r.funct == `FUNCT_AND) val = a & b;
        else if (w.r.op == `OP_SPECIAL && r_form && w.r.funct == `FUNCT_OR) val = a | b;
        else if (w.r.op == `OP_SPECIAL2 && r_form && w.r.funct == `FUNCT_MUL) val = a * b;
        else if (w.i.op == `OP_ORI) begin
            dst = w.i.rt;
            val = a | {16'd0, w.i.imm};
        end else if (w.i.op == `OP_LUI) begin
            dst = w.i.rt;
            val = {w.i.imm, 16'd0};
        end else legal = 1'b0;
        wr = legal && (dst != 5'd0);
    endtask

    task automatic check_cycle();
        check_value(e_addr, exp_e_addr, "e_addr");
        check_value(32'(unknown_e), 32'(exp_unknown), "unknown_e");
        if (exp_due.size() > 0 && exp_due[0] == cyc) begin
            check_value(32'(m_wr_en), 32'd1, "m_wr_en");
            check_value(32'(m_wr_addr), 32'(exp_addr.pop_front()), "m_wr_addr");
            check_value(m_result, exp_data.pop_front(), "m_result");
            void'(exp_due.pop_front());
        end else begin
            check_value(32'(m_wr_en), 32'd0, "m_wr_en");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One clock of D presentation, output checks and model update
    //////////////////////////////////////////////////////////////////////
    task automatic run_cycle(input logic [31:0] word, input logic [31:0] addr, input logic exc,
                             input logic want_stall, output logic taken);
        pipe_pkg::instr_word_u w;
        logic                  eret_in_e;
        logic                  legal;
        logic                  wr;
        logic [4:0]            dst;
        logic [31:0]           val;
        w         = word;
        eret_in_e = eret_next;
        eret_next = 1'b0;
        @(posedge clk);
        cyc = cyc + 1;
        instr      <= w;
        instr_addr <= addr;
        exc_req    <= exc;
        rs_data    <= reg_read(w.r.rs);
        rt_data    <= reg_read(w.r.rt);
        @(negedge clk);
        check_cycle();
        check_value(32'(stall_d), 32'(want_stall && !exc && !eret_in_e), "stall_d");
        taken       = !exc && !eret_in_e && !want_stall;
        exp_unknown = 1'b0;
        last_wr     = 5'd0;
        if (exc) exp_e_addr = `HANDLER_ADDR;
        else if (eret_in_e) exp_e_addr = EPC_VALUE;   // D is flushed by eret
        else exp_e_addr = addr;
        if (taken) begin
            ref_execute(w, legal, wr, dst, val);
            exp_unknown = !legal;
            eret_next   = (word == `ERET_WORD);
            if (wr) begin
                last_wr  = dst;
                last_old = regs[dst];
                regs[dst] = val;
                exp_due.push_back(cyc + 2);
                exp_addr.push_back(dst);
                exp_data.push_back(val);
            end
        end
    endtask

    initial begin
        int   idx;
        int   guard;
        logic taken;
        logic exc_now;
        logic stall_now;
        logic exc_done;
        logic stall_done;
        clk         = 1'b0;
        reset       = 1'b1;
        instr       = NOP_WORD;
        instr_addr  = NOP_ADDR;
        rs_data     = 32'd0;
        rt_data     = 32'd0;
        exc_req     = 1'b0;
        epc         = EPC_VALUE;
        errors      = 0;
        checks      = 0;
        cyc         = 0;
        last_wr     = 5'd0;
        last_old    = 32'd0;
        eret_next   = 1'b0;
        exp_unknown = 1'b0;
        exp_e_addr  = `RESET_ADDR;
        void'($urandom(37082));
        regs[0]     = 32'd0;
        for (int i = 1; i < 32; i++) regs[i] = $urandom();
        load_program();

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_cycle();
        check_value(32'(stall_d), 32'd0, "stall_d after reset");
        exp_e_addr = NOP_ADDR;

        idx        = 0;
        guard      = 0;
        exc_done   = 1'b0;
        stall_done = 1'b0;
        while (idx < tab_word.size() && guard < MAX_CYCLES) begin
            exc_now   = tab_exc[idx] && !exc_done;
            stall_now = tab_stall[idx] && !stall_done && !exc_now;
            run_cycle(tab_word[idx], `RESET_ADDR + 32'(4 * idx), exc_now, stall_now, taken);
            exc_done   = exc_done || exc_now;
            stall_done = stall_done || stall_now;
            if (taken) begin
                idx        = idx + 1;
                exc_done   = 1'b0;
                stall_done = 1'b0;
            end
            guard = guard + 1;
        end
        if (idx < tab_word.size()) begin
            errors = errors + 1;
            $display("Timeout: program not finished after %0d cycles", MAX_CYCLES);
        end

        guard = 0;
        while (exp_due.size() > 0 && guard < 10) begin
            run_cycle(NOP_WORD, NOP_ADDR, 1'b0, 1'b0, taken);
            guard = guard + 1;
        end
        if (exp_due.size() > 0) begin
            errors = errors + 1;
            $display("Timeout: %0d write-backs never appeared", exp_due.size());
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/pipe_pkg.sv
hdl/instr_decoder.sv
hdl/hazard_ctrl.sv
hdl/flow_reg_e.sv
hdl/exec_unit.sv
hdl/exec_core_top.sv
verification/exec_core_tb.sv

/* Makefile */
# Verilator build and run for the D/E pipeline slice

VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Testbench reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
